//--- rtl/itlb_pkg.sv
// ITLB shared definitions
`default_nettype none

package itlb_pkg;

    // Sv39 address geometry.
    localparam int va_len       = 39;
    localparam int pa_len       = 40;
    localparam int page_bits    = 12;
    localparam int itlb_entries = 4;
    localparam int flag_bits    = 7;

    typedef logic [va_len-1:0]           va_t;
    typedef logic [pa_len-1:0]           pa_t;
    typedef logic [va_len-page_bits-1:0] vpn_t;
    typedef logic [pa_len-page_bits-1:0] ppn_t;
    typedef logic [itlb_entries-1:0]     entry_sel_t;
    typedef logic [1:0]                  priv_t;
    typedef logic [flag_bits-1:0]        itlb_flags_t;

    // Bit positions inside the flag vector returned by the page walker.
    localparam int flag_v  = 0;
    localparam int flag_x  = 1;
    localparam int flag_u  = 2;
    localparam int flag_g  = 3;
    localparam int flag_a  = 4;
    localparam int flag_pf = 5;  // Walker found a bad PTE.
    localparam int flag_af = 6;  // Walker hit a bus error.

    localparam priv_t priv_user       = 2'b00;
    localparam priv_t priv_supervisor = 2'b01;

endpackage

`default_nettype wire

//--- rtl/itlb_entry_array.sv
// ITLB entry array
`default_nettype none

module itlb_entry_array (
    input  logic                  core_clk,
    input  logic                  core_reset_n,
    input  itlb_pkg::va_t         fetch_va,
    input  itlb_pkg::entry_sel_t  victim_sel,
    input  logic                  miss_resp,
    input  itlb_pkg::vpn_t        miss_vpn,
    input  itlb_pkg::ppn_t        miss_ppn,
    input  itlb_pkg::itlb_flags_t miss_flags,
    input  logic                  sfence_req,
    input  logic                  satp_we,
    output itlb_pkg::entry_sel_t  hit_sel,
    output itlb_pkg::entry_sel_t  valid_vec,
    output itlb_pkg::ppn_t        hit_ppn,
    output itlb_pkg::itlb_flags_t hit_flags
);
    import itlb_pkg::*;

    vpn_t        vpn_q   [itlb_entries];
    ppn_t        ppn_q   [itlb_entries];
    itlb_flags_t flags_q [itlb_entries];
    logic        valid_q [itlb_entries];
    entry_sel_t  fill_sel;
    entry_sel_t  flush_sel;
    vpn_t        fetch_vpn;
    logic        flush_any;

    assign fetch_vpn = fetch_va[va_len-1:page_bits];
    assign flush_any = sfence_req | satp_we;  // Any flush blocks a fill in the same cycle.

    for (genvar i = 0; i < itlb_entries; i++) begin : g_entry
        assign fill_sel[i] = miss_resp & victim_sel[i] & ~flush_any;

        // A SATP write spares the global mappings.
        assign flush_sel[i] = sfence_req
                            | (satp_we & valid_q[i] & ~flags_q[i][flag_g]);

        assign hit_sel[i]   = valid_q[i] & (vpn_q[i] == fetch_vpn);
        assign valid_vec[i] = valid_q[i];

        always_ff @(posedge core_clk or negedge core_reset_n) begin
            if (!core_reset_n) begin
                valid_q[i] <= 1'b0;
            end else if (flush_sel[i]) begin
                valid_q[i] <= 1'b0;
            end else if (fill_sel[i]) begin
                valid_q[i] <= miss_flags[flag_v];  // Invalid walker result leaves it empty.
            end
        end

        always_ff @(posedge core_clk) begin
            if (fill_sel[i]) begin
                vpn_q[i]   <= miss_vpn;
                ppn_q[i]   <= miss_ppn;
                flags_q[i] <= miss_flags;
            end
        end
    end

    // At most one entry matches, so an AND-OR mux is enough.
    always_comb begin
        hit_ppn   = '0;
        hit_flags = '0;
        for (int i = 0; i < itlb_entries; i++) begin
            hit_ppn   = hit_ppn | ({$bits(ppn_t){hit_sel[i]}} & ppn_q[i]);
            hit_flags = hit_flags | ({$bits(itlb_flags_t){hit_sel[i]}} & flags_q[i]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/itlb_plru.sv
// ITLB tree pseudo-LRU
`default_nettype none

module itlb_plru (
    input  logic                 core_clk,
    input  logic                 core_reset_n,
    input  logic                 fetch_valid,
    input  logic                 translate_en,
    input  itlb_pkg::entry_sel_t hit_sel,
    input  itlb_pkg::entry_sel_t valid_vec,
    input  logic                 miss_resp,
    output itlb_pkg::entry_sel_t victim_sel
);
    import itlb_pkg::*;

    logic [2:0] tree_q;  // Bit 0 is the root, bits 1 and 2 choose inside each pair.
    entry_sel_t tree_sel;
    entry_sel_t free_sel;
    entry_sel_t used_sel;
    logic       hit_upd;
    logic       update;

    assign tree_sel[0] = ~tree_q[0] & ~tree_q[1];
    assign tree_sel[1] = ~tree_q[0] &  tree_q[1];
    assign tree_sel[2] =  tree_q[0] & ~tree_q[2];
    assign tree_sel[3] =  tree_q[0] &  tree_q[2];

    // Isolates the lowest clear bit of the valid vector.
    assign free_sel = ~valid_vec & (valid_vec + 1'b1);

    assign victim_sel = (|free_sel) ? free_sel : tree_sel;

    assign hit_upd  = fetch_valid & translate_en & (|hit_sel);
    assign update   = hit_upd | miss_resp;
    assign used_sel = miss_resp ? victim_sel : hit_sel;  // A fill outranks a hit.

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            tree_q <= 3'b000;
        end else if (update) begin
            tree_q[0] <= |used_sel[1:0];
            if (|used_sel[1:0]) begin
                tree_q[1] <= used_sel[0];
            end
            if (|used_sel[3:2]) begin
                tree_q[2] <= used_sel[2];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/itlb_miss_ctrl.sv
// ITLB miss request control
`default_nettype none

module itlb_miss_ctrl (
    input  logic                 core_clk,
    input  logic                 core_reset_n,
    input  logic                 fetch_valid,
    input  itlb_pkg::va_t        fetch_va,
    input  logic                 translate_en,
    input  itlb_pkg::entry_sel_t hit_sel,
    input  logic                 miss_resp,
    output logic                 miss_req,
    output itlb_pkg::vpn_t       miss_vpn
);
    import itlb_pkg::*;

    logic miss_det;
    logic miss_req_q;
    vpn_t miss_vpn_q;

    // Only one walk is outstanding, so a pending request masks new misses.
    assign miss_det = fetch_valid & translate_en & ~(|hit_sel) & ~miss_req_q;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            miss_req_q <= 1'b0;
        end else begin
            miss_req_q <= (miss_det | miss_req_q) & ~miss_resp;
        end
    end

    always_ff @(posedge core_clk) begin
        if (miss_det) begin
            miss_vpn_q <= fetch_va[va_len-1:page_bits];
        end
    end

    assign miss_req = miss_req_q;
    assign miss_vpn = miss_vpn_q;  // Held for the whole walk.

endmodule

`default_nettype wire

//--- rtl/itlb_check.sv
// ITLB permission check
`default_nettype none

module itlb_check (
    input  itlb_pkg::va_t         fetch_va,
    input  logic                  translate_en,
    input  itlb_pkg::priv_t       cur_privilege,
    input  itlb_pkg::entry_sel_t  hit_sel,
    input  itlb_pkg::ppn_t        hit_ppn,
    input  itlb_pkg::itlb_flags_t hit_flags,
    output logic                  fetch_hit,
    output itlb_pkg::pa_t         fetch_pa,
    output logic                  fetch_page_fault,
    output logic                  fetch_access_fault
);
    import itlb_pkg::*;

    logic any_hit;
    logic is_user;
    logic is_super;
    logic perm_fault;
    pa_t  bypass_pa;
    pa_t  xlate_pa;

    assign any_hit  = |hit_sel;
    assign is_user  = (cur_privilege == priv_user);
    assign is_super = (cur_privilege == priv_supervisor);

    assign bypass_pa = {{(pa_len - va_len){1'b0}}, fetch_va};
    assign xlate_pa  = {hit_ppn, fetch_va[page_bits-1:0]};

    // Supervisor may not execute from user pages, and user only from user pages.
    assign perm_fault = hit_flags[flag_pf]
                      | ~hit_flags[flag_x]
                      | ~hit_flags[flag_a]
                      | (hit_flags[flag_u] & is_super)
                      | (~hit_flags[flag_u] & is_user);

    assign fetch_hit = translate_en ? any_hit : 1'b1;
    assign fetch_pa  = translate_en ? xlate_pa : bypass_pa;

    assign fetch_access_fault = translate_en & any_hit & hit_flags[flag_af];
    assign fetch_page_fault   = translate_en & any_hit & ~hit_flags[flag_af] & perm_fault;

endmodule

`default_nettype wire

//--- rtl/itlb_top.sv
// Instruction TLB top level
`default_nettype none

module itlb_top (
    input  logic                  core_clk,
    input  logic                  core_reset_n,
    input  logic                  fetch_valid,
    input  itlb_pkg::va_t         fetch_va,
    output logic                  fetch_hit,
    output itlb_pkg::pa_t         fetch_pa,
    output logic                  fetch_page_fault,
    output logic                  fetch_access_fault,
    input  logic                  translate_en,
    input  itlb_pkg::priv_t       cur_privilege,
    input  logic                  satp_we,
    input  logic                  sfence_req,
    output logic                  miss_req,
    output itlb_pkg::vpn_t        miss_vpn,
    input  logic                  miss_resp,
    input  itlb_pkg::ppn_t        miss_ppn,
    input  itlb_pkg::itlb_flags_t miss_flags
);
    import itlb_pkg::*;

    entry_sel_t  hit_sel;
    entry_sel_t  valid_vec;
    entry_sel_t  victim_sel;
    ppn_t        hit_ppn;
    itlb_flags_t hit_flags;

    itlb_entry_array u_entry_array (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .fetch_va     (fetch_va),
        .victim_sel   (victim_sel),
        .miss_resp    (miss_resp),
        .miss_vpn     (miss_vpn),
        .miss_ppn     (miss_ppn),
        .miss_flags   (miss_flags),
        .sfence_req   (sfence_req),
        .satp_we      (satp_we),
        .hit_sel      (hit_sel),
        .valid_vec    (valid_vec),
        .hit_ppn      (hit_ppn),
        .hit_flags    (hit_flags)
    );

    itlb_plru u_plru (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .fetch_valid  (fetch_valid),
        .translate_en (translate_en),
        .hit_sel      (hit_sel),
        .valid_vec    (valid_vec),
        .miss_resp    (miss_resp),
        .victim_sel   (victim_sel)
    );

    itlb_miss_ctrl u_miss_ctrl (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .fetch_valid  (fetch_valid),
        .fetch_va     (fetch_va),
        .translate_en (translate_en),
        .hit_sel      (hit_sel),
        .miss_resp    (miss_resp),
        .miss_req     (miss_req),
        .miss_vpn     (miss_vpn)
    );

    itlb_check u_check (
        .fetch_va           (fetch_va),
        .translate_en       (translate_en),
        .cur_privilege      (cur_privilege),
        .hit_sel            (hit_sel),
        .hit_ppn            (hit_ppn),
        .hit_flags          (hit_flags),
        .fetch_hit          (fetch_hit),
        .fetch_pa           (fetch_pa),
        .fetch_page_fault   (fetch_page_fault),
        .fetch_access_fault (fetch_access_fault)
    );

endmodule

`default_nettype wire

//--- testbench/itlb_clock_gen.sv
// ITLB testbench clock and reset
`default_nettype none

module itlb_clock_gen (
    output logic core_clk,
    output logic core_reset_n
);
    localparam int half_period = 20;  // Full period is 40.

    initial begin
        core_clk = 1'b0;
        forever #half_period core_clk = ~core_clk;
    end

    initial begin
        core_reset_n = 1'b0;
        repeat (4) @(posedge core_clk);
        core_reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/itlb_props.sv
// ITLB walker handshake assertions
`default_nettype none

module itlb_props (
    input logic                 core_clk,
    input logic                 core_reset_n,
    input logic                 miss_req,
    input itlb_pkg::vpn_t       miss_vpn,
    input logic                 miss_resp,
    input itlb_pkg::entry_sel_t victim_sel
);

    reset_quiet: assert property (@(posedge core_clk) !core_reset_n |-> !miss_req)
        else $error("miss_req is high while reset is asserted");

    // The walker relies on the VPN for the whole walk.
    vpn_stable: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        miss_req && $past(miss_req) |-> $stable(miss_vpn))
        else $error("miss_vpn changed while miss_req was high");

    resp_needs_req: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        miss_resp |-> miss_req)
        else $error("miss_resp arrived without a pending miss_req");

    victim_onehot: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        $onehot(victim_sel))
        else $error("victim_sel is not one-hot");

endmodule

bind itlb_top itlb_props u_props (
    .core_clk     (core_clk),
    .core_reset_n (core_reset_n),
    .miss_req     (miss_req),
    .miss_vpn     (miss_vpn),
    .miss_resp    (miss_resp),
    .victim_sel   (victim_sel)
);

`default_nettype wire

//--- testbench/itlb_tb.sv
// ITLB testbench
`default_nettype none

module itlb_tb;
    import itlb_pkg::*;

    localparam int rec_words   = 10;  // Columns per record in the tests file.
    localparam int max_records = 64;
    localparam int wait_limit  = 50;

    localparam logic [3:0] op_lookup = 4'h0;
    localparam logic [3:0] op_fill   = 4'h1;
    localparam logic [3:0] op_sfence = 4'h2;
    localparam logic [3:0] op_satp   = 4'h3;
    localparam logic [3:0] op_end    = 4'hf;

    logic        core_clk;
    logic        core_reset_n;
    logic        fetch_valid;
    va_t         fetch_va;
    logic        fetch_hit;
    pa_t         fetch_pa;
    logic        fetch_page_fault;
    logic        fetch_access_fault;
    logic        translate_en;
    priv_t       cur_privilege;
    logic        satp_we;
    logic        sfence_req;
    logic        miss_req;
    vpn_t        miss_vpn;
    logic        miss_resp;
    ppn_t        miss_ppn;
    itlb_flags_t miss_flags;

    logic [63:0] tests [rec_words*max_records];
    int          error_count;
    int          check_count;
    logic        timed_out;
    logic        req_pending;  // A walk the testbench expects to be open.

    itlb_clock_gen u_clock_gen (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n)
    );

    itlb_top dut0 (
        .core_clk           (core_clk),
        .core_reset_n       (core_reset_n),
        .fetch_valid        (fetch_valid),
        .fetch_va           (fetch_va),
        .fetch_hit          (fetch_hit),
        .fetch_pa           (fetch_pa),
        .fetch_page_fault   (fetch_page_fault),
        .fetch_access_fault (fetch_access_fault),
        .translate_en       (translate_en),
        .cur_privilege      (cur_privilege),
        .satp_we            (satp_we),
        .sfence_req         (sfence_req),
        .miss_req           (miss_req),
        .miss_vpn           (miss_vpn),
        .miss_resp          (miss_resp),
        .miss_ppn           (miss_ppn),
        .miss_flags         (miss_flags)
    );

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic run_lookup(input logic fv, input priv_t priv, input logic ten, input va_t va,
                              input logic exp_hit, input pa_t exp_pa, input logic [1:0] exp_flt);
        logic exp_req;
        exp_req = req_pending | (fv & ten & ~exp_hit);  // A translated miss opens a walk.
        @(posedge core_clk);
        fetch_valid   <= fv;
        fetch_va      <= va;
        translate_en  <= ten;
        cur_privilege <= priv;
        @(negedge core_clk);
        check_value("fetch_hit", fetch_hit, exp_hit);
        if (exp_hit) begin
            check_value("fetch_pa", fetch_pa, exp_pa);
        end
        check_value("fetch_page_fault", fetch_page_fault, exp_flt[0]);
        check_value("fetch_access_fault", fetch_access_fault, exp_flt[1]);
        @(posedge core_clk);
        fetch_valid <= 1'b0;
        @(negedge core_clk);
        check_value("miss_req", miss_req, exp_req);
        req_pending = exp_req;
    endtask

    task automatic serve_fill(input va_t va, input ppn_t ppn, input itlb_flags_t flags);
        int waited;
        waited = 0;
        @(posedge core_clk);
        fetch_valid  <= 1'b1;
        fetch_va     <= va;
        translate_en <= 1'b1;
        @(negedge core_clk);
        while (!miss_req && waited < wait_limit) begin
            @(negedge core_clk);
            waited++;
        end
        if (!miss_req) begin
            $display("ERROR: no miss request for VA 0x%0h within %0d cycles", va, wait_limit);
            error_count++;
            timed_out = 1'b1;
        end else begin
            check_value("miss_vpn", miss_vpn, va[va_len-1:page_bits]);
            @(posedge core_clk);
            fetch_valid <= 1'b0;
            miss_resp   <= 1'b1;
            miss_ppn    <= ppn;
            miss_flags  <= flags;
            @(posedge core_clk);
            miss_resp <= 1'b0;
            @(negedge core_clk);
            check_value("miss_req", miss_req, 1'b0);
        end
        req_pending = 1'b0;
    endtask

    task automatic pulse_flush(input logic is_sfence);
        @(posedge core_clk);
        sfence_req <= is_sfence;
        satp_we    <= ~is_sfence;
        @(posedge core_clk);
        sfence_req <= 1'b0;
        satp_we    <= 1'b0;
    endtask

    initial begin
        int         rec;
        int         base;
        int         waited;
        logic [3:0] op;
        logic       done;
        fetch_valid   = 1'b0;
        fetch_va      = '0;
        translate_en  = 1'b0;
        cur_privilege = priv_supervisor;
        satp_we       = 1'b0;
        sfence_req    = 1'b0;
        miss_resp     = 1'b0;
        miss_ppn      = '0;
        miss_flags    = '0;
        error_count   = 0;
        check_count   = 0;
        timed_out     = 1'b0;
        req_pending   = 1'b0;
        $readmemh("testbench/itlb_tests.txt", tests);

        waited = 0;
        while (core_reset_n !== 1'b1 && waited < wait_limit) begin
            @(negedge core_clk);
            waited++;
        end
        if (core_reset_n !== 1'b1) begin
            $display("ERROR: reset was never released");
            error_count++;
            timed_out = 1'b1;
        end

        rec  = 0;
        done = timed_out;
        while (!done) begin
            base = rec * rec_words;
            op   = tests[base][3:0];
            case (op)
                op_lookup: run_lookup(tests[base+1][0], tests[base+2][1:0], tests[base+3][0],
                                      tests[base+4][va_len-1:0], tests[base+7][0],
                                      tests[base+8][pa_len-1:0], tests[base+9][1:0]);
                op_fill:   serve_fill(tests[base+4][va_len-1:0], tests[base+5][27:0],
                                      tests[base+6][6:0]);
                op_sfence: pulse_flush(1'b1);
                op_satp:   pulse_flush(1'b0);
                op_end:    done = 1'b1;
                default: begin
                    $display("ERROR: record %0d has no known operation", rec);
                    error_count++;
                    done = 1'b1;
                end
            endcase
            rec++;
            if (timed_out || rec >= max_records) begin
                done = 1'b1;
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/itlb_tests.txt
// op(0 lookup 1 fill 2 sfence 3 satp f end) fetch_valid priv translate va ppn flags
// exp_hit exp_pa exp_fault(bit0 page, bit1 access); flags v1 x2 u4 g8 a10 pf20 af40
0 1 1 0 123456789a 0 0 1 123456789a 0
0 1 1 0 7ffffff001 0 0 1 7ffffff001 0
// Miss, fill, then hit.
0 1 1 1 401234 0 0 0 0 0
1 0 1 1 401234 abcde12 13 0 0 0
0 1 1 1 401ffc 0 0 1 abcde12ffc 0
// Permission faults.
0 1 0 1 401ffc 0 0 1 abcde12ffc 1
1 0 1 1 402000 402 11 0 0 0
0 1 1 1 402010 0 0 1 402010 1
1 0 1 1 403000 403 03 0 0 0
0 1 1 1 403020 0 0 1 403020 1
1 0 1 1 404000 1000404 17 0 0 0
0 1 1 1 404040 0 0 1 1000404040 1
0 1 0 1 404040 0 0 1 1000404040 0
1 0 1 1 405000 405 33 0 0 0
0 1 1 1 405050 0 0 1 405050 1
1 0 1 1 406000 406 73 0 0 0
0 1 1 1 406060 0 0 1 406060 2
// Replacement: after A is used, E must take the slot of C.
2 0 0 0 0 0 0 0 0 0
1 0 1 1 501000 2000501 13 0 0 0
1 0 1 1 502000 2000502 13 0 0 0
1 0 1 1 503000 2000503 13 0 0 0
1 0 1 1 504000 2000504 13 0 0 0
0 1 1 1 501abc 0 0 1 2000501abc 0
1 0 1 1 505000 2000505 13 0 0 0
0 1 1 1 501abc 0 0 1 2000501abc 0
0 1 1 1 502abc 0 0 1 2000502abc 0
0 1 1 1 504abc 0 0 1 2000504abc 0
0 1 1 1 505abc 0 0 1 2000505abc 0
0 0 1 1 503abc 0 0 0 0 0
// Flushes: SATP keeps the global page, SFENCE drops both.
2 0 0 0 0 0 0 0 0 0
1 0 1 1 601000 3000601 1b 0 0 0
1 0 1 1 602000 3000602 13 0 0 0
0 1 1 1 601123 0 0 1 3000601123 0
0 1 1 1 602123 0 0 1 3000602123 0
3 0 0 0 0 0 0 0 0 0
0 1 1 1 601123 0 0 1 3000601123 0
0 0 1 1 602123 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0
0 0 1 1 601123 0 0 0 0 0
0 0 1 1 602123 0 0 0 0 0
f 0 0 0 0 0 0 0 0 0

//--- itlb.f
rtl/itlb_pkg.sv
rtl/itlb_entry_array.sv
rtl/itlb_plru.sv
rtl/itlb_miss_ctrl.sv
rtl/itlb_check.sv
rtl/itlb_top.sv
testbench/itlb_clock_gen.sv
testbench/itlb_props.sv
testbench/itlb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the ITLB testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module itlb_tb \
    -f itlb.f \
    -o itlb_sim

./obj_dir/itlb_sim 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation did not pass, see sim.log."
    exit 1
fi
